// ==== Bender.yml ====
package:
  name: stride_sched

sources:
  - files:
      - verilog/sched_pkg.sv
      - verilog/stride_alloc.sv
      - verilog/stride_entry.sv
      - verilog/prefetch_arbiter.sv
      - verilog/dispatch_select.sv
      - verilog/stride_sched_top.sv
  - target: test
    files:
      - dv/tb_stride_sched.sv

// ==== compile.f ====
verilog/sched_pkg.sv
verilog/stride_alloc.sv
verilog/stride_entry.sv
verilog/prefetch_arbiter.sv
verilog/dispatch_select.sv
verilog/stride_sched_top.sv
dv/tb_stride_sched.sv

// ==== dv/tb_stride_sched.sv ====
/* testbench for the scheduler core, checks run as concurrent assertions
   against a model of the selection rules while tasks steer the stimulus */
`timescale 1ns/1ps
`default_nettype none

module tb_stride_sched
  import sched_pkg::*;
();

  logic          clk;
  logic          rst;
  commit_pkt_s   commit_pkt;
  issue_pkt_s    issue_pkt;
  late_wb_pkt_s  late_wb_pkt;
  logic          hazard;
  logic          resume;
  logic          irq_pending;
  dispatch_pkt_s dispatch_pkt;
  logic          late_wb_yumi;
  logic          fe_read;

  integer        seed;
  int            errors;
  int            tests_run;
  int            tests_failed;
  int            pref_expected;
  int            pref_taken;
  vaddr_t        exp_pref_addr;
  logic          queued;
  dispatch_pkt_s exp_pkt;

  stride_sched_top UUT (
    .clk_i          (clk),
    .rst_i          (rst),
    .commit_pkt_i   (commit_pkt),
    .issue_pkt_i    (issue_pkt),
    .late_wb_pkt_i  (late_wb_pkt),
    .hazard_i       (hazard),
    .resume_i       (resume),
    .irq_pending_i  (irq_pending),
    .dispatch_pkt_o (dispatch_pkt),
    .late_wb_yumi_o (late_wb_yumi),
    .fe_read_o      (fe_read)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reference model of the priority rules
  always_comb
  begin
    queued  = issue_pkt.v && !hazard;
    exp_pkt = '0;
    if (late_wb_pkt.v && (late_wb_pkt.force_v || !queued))
    begin
      exp_pkt.src     = e_src_wb;
      exp_pkt.rd_addr = late_wb_pkt.rd_addr;
      exp_pkt.rs2     = late_wb_pkt.data;
    end
    else if (!late_wb_pkt.v && !hazard && resume)
    begin
      exp_pkt.src        = e_src_resume;
      exp_pkt.exc.resume = 1'b1;
    end
    else if (UUT.pref_req.v)
    begin
      exp_pkt.src = e_src_pref;
      exp_pkt.rs1 = dword_t'(exp_pref_addr);
    end
    else if (!late_wb_pkt.v && !hazard && irq_pending)
    begin
      exp_pkt.src     = e_src_irq;
      exp_pkt.exc.irq = 1'b1;
    end
    else if (queued)
    begin
      exp_pkt.instr = issue_pkt.instr;
      exp_pkt.rs2   = issue_pkt.imm;
      exp_pkt.src   = issue_pkt.instr_v ? e_src_fe_instr : e_src_fe_exc;
      if (!issue_pkt.instr_v)
      begin
        exp_pkt.rs1      = dword_t'(issue_pkt.pc);
        exp_pkt.exc.code = issue_pkt.exc_code;
      end
    end
    exp_pkt.v  = (exp_pkt.src != e_src_none);
    exp_pkt.pc = issue_pkt.pc;
  end

  always @(posedge clk)
  begin
    if (!rst && dispatch_pkt.v && dispatch_pkt.src == e_src_pref)
    begin
      pref_taken <= pref_taken + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] got_val);
    $display("error at %0t ns: %s expected %0h got %0h", $time, name, exp_val, got_val);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("failure at %0t ns: %s", $time, what);
    errors++;
  endtask

  a_v: assert property (@(posedge clk) disable iff (rst) dispatch_pkt.v == exp_pkt.v)
    else report_mismatch("dispatch_pkt_o.v", $sampled(exp_pkt.v), $sampled(dispatch_pkt.v));
  a_src: assert property (@(posedge clk) disable iff (rst) dispatch_pkt.src == exp_pkt.src)
    else report_mismatch("dispatch_pkt_o.src", $sampled(exp_pkt.src), $sampled(dispatch_pkt.src));
  a_pc: assert property (@(posedge clk) disable iff (rst) dispatch_pkt.pc == exp_pkt.pc)
    else report_mismatch("dispatch_pkt_o.pc", $sampled(exp_pkt.pc), $sampled(dispatch_pkt.pc));
  a_instr: assert property (@(posedge clk) disable iff (rst) dispatch_pkt.instr == exp_pkt.instr)
    else report_mismatch("dispatch_pkt_o.instr", $sampled(exp_pkt.instr),
                         $sampled(dispatch_pkt.instr));
  a_rd: assert property (@(posedge clk) disable iff (rst)
    dispatch_pkt.rd_addr == exp_pkt.rd_addr)
    else report_mismatch("dispatch_pkt_o.rd_addr", $sampled(exp_pkt.rd_addr),
                         $sampled(dispatch_pkt.rd_addr));
  a_rs1: assert property (@(posedge clk) disable iff (rst) dispatch_pkt.rs1 == exp_pkt.rs1)
    else report_mismatch("dispatch_pkt_o.rs1", $sampled(exp_pkt.rs1), $sampled(dispatch_pkt.rs1));
  a_rs2: assert property (@(posedge clk) disable iff (rst) dispatch_pkt.rs2 == exp_pkt.rs2)
    else report_mismatch("dispatch_pkt_o.rs2", $sampled(exp_pkt.rs2), $sampled(dispatch_pkt.rs2));
  a_exc: assert property (@(posedge clk) disable iff (rst) dispatch_pkt.exc == exp_pkt.exc)
    else report_mismatch("dispatch_pkt_o.exc", $sampled(exp_pkt.exc), $sampled(dispatch_pkt.exc));
  a_wb_yumi: assert property (@(posedge clk) disable iff (rst)
    late_wb_yumi == (exp_pkt.src == e_src_wb))
    else report_mismatch("late_wb_yumi_o", $sampled(exp_pkt.src == e_src_wb),
                         $sampled(late_wb_yumi));
  a_fe_read: assert property (@(posedge clk) disable iff (rst)
    fe_read == (exp_pkt.src inside {e_src_fe_instr, e_src_fe_exc}))
    else report_mismatch("fe_read_o", $sampled(exp_pkt.src inside {e_src_fe_instr, e_src_fe_exc}),
                         $sampled(fe_read));
  a_one_winner: assert property (@(posedge clk) disable iff (rst) !(late_wb_yumi && fe_read))
    else report_failure("writeback and fetch queue were both taken in one cycle");
  a_hazard: assert property (@(posedge clk) disable iff (rst)
    hazard |-> !fe_read && !(dispatch_pkt.src inside {e_src_resume, e_src_irq}))
    else report_failure("resume, interrupt or fetch queue chosen while hazard was high");
  a_pref_once: assert property (@(posedge clk) disable iff (rst)
    dispatch_pkt.v && dispatch_pkt.src == e_src_pref |-> pref_taken < pref_expected)
    else report_failure("prefetch dispatched without a trained stride");
  a_slot_addr: assert property (@(posedge clk) disable iff (rst)
    UUT.pref_req.v |-> UUT.pref_req.addr == exp_pref_addr)
    else report_mismatch("pref_req.addr", $sampled(exp_pref_addr), $sampled(UUT.pref_req.addr));

  task automatic drive_idle();
    commit_pkt  = '0;
    issue_pkt   = '0;
    late_wb_pkt = '0;
    hazard      = 1'b0;
    resume      = 1'b0;
    irq_pending = 1'b0;
  endtask

  task automatic close_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before)
    begin
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: failing with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic commit_load(input vaddr_t pc, input vaddr_t addr);
    @(negedge clk);
    commit_pkt = '{v: 1'b1, is_load: 1'b1, pc: pc, vaddr: addr};
    @(negedge clk);
    commit_pkt = '0;
    @(negedge clk);
  endtask

  // n loads at a constant stride where the last one triggers the prefetch
  task automatic train_stride(input vaddr_t pc, input vaddr_t base, input int s, input int n);
    exp_pref_addr = vaddr_t'(longint'(base) + longint'(n) * s);
    pref_expected++;
    for (int k = 0; k < n; k++)
    begin
      commit_load(pc, vaddr_t'(longint'(base) + longint'(k) * s));
    end
  endtask

  task automatic wait_prefetch(input int limit);
    int n;
    n = 0;
    while (pref_taken < pref_expected && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (pref_taken < pref_expected)
    begin
      report_failure("timeout waiting for the prefetch dispatch");
    end
  endtask

  task automatic wait_slot_valid(input int limit);
    int n;
    n = 0;
    while (!UUT.pref_req.v && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (!UUT.pref_req.v)
    begin
      report_failure("timeout waiting for the prefetch slot to fill");
    end
  endtask

  task automatic late_wb_cases();
    @(negedge clk);
    issue_pkt         = '0;
    issue_pkt.v       = 1'b1;
    issue_pkt.instr_v = 1'b1;
    issue_pkt.pc      = 39'h100;
    issue_pkt.instr   = 32'h0000_0013;
    issue_pkt.imm     = 64'h5;
    late_wb_pkt       = '{v: 1'b1, force_v: 1'b0, rd_addr: 5'd7, data: 64'hdead_beef_0123};
    @(negedge clk);
    late_wb_pkt.force_v = 1'b1;
    @(negedge clk);
    late_wb_pkt.force_v = 1'b0;
    issue_pkt.v         = 1'b0;
    @(negedge clk);
    issue_pkt.v = 1'b1;
    hazard      = 1'b1;
    @(negedge clk);
    drive_idle();
  endtask

  task automatic random_mix(input int cycles);
    logic [31:0] rnd;
    for (int i = 0; i < cycles; i++)
    begin
      @(negedge clk);
      rnd                 = $random(seed);
      hazard              = (rnd[1:0] == 2'b00);
      resume              = (rnd[4:2] == 3'b000);
      irq_pending         = rnd[5];
      late_wb_pkt.v       = rnd[6] & rnd[7];
      late_wb_pkt.force_v = rnd[8];
      late_wb_pkt.rd_addr = rnd[13:9];
      late_wb_pkt.data    = {$random(seed), $random(seed)};
      issue_pkt.v         = rnd[14] | rnd[15];
      issue_pkt.instr_v   = rnd[16] | rnd[17];
      issue_pkt.exc_code  = rnd[21:18];
      issue_pkt.pc        = vaddr_t'({$random(seed), $random(seed)});
      issue_pkt.instr     = $random(seed);
      issue_pkt.imm       = {$random(seed), $random(seed)};
    end
    @(negedge clk);
    drive_idle();
  endtask

  initial
  begin
    int e0;
    int strides [6];
    vaddr_t addr;
    strides       = '{3, 7, -2, 5, 11, -9};
    seed          = 52223;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    pref_expected = 0;
    pref_taken    = 0;
    exp_pref_addr = '0;
    rst           = 1'b1;
    drive_idle();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    e0 = errors;
    repeat (8) @(negedge clk);
    close_test("reset_idle", e0);

    e0 = errors;
    late_wb_cases();
    close_test("late_writeback", e0);

    e0 = errors;
    random_mix(400);
    close_test("random_priority", e0);

    e0 = errors;
    train_stride(39'h1000, 39'h8000, 16, 5);
    wait_prefetch(40);
    // irregular strides never repeat, so no prefetch may follow
    addr = 39'h4_0000;
    commit_load(39'h2000, addr);
    for (int k = 0; k < 6; k++)
    begin
      addr = vaddr_t'(longint'(addr) + strides[k]);
      commit_load(39'h2000, addr);
    end
    repeat (20) @(negedge clk);
    close_test("stride_training", e0);

    e0 = errors;
    @(negedge clk);
    resume = 1'b1;
    train_stride(39'h3000, 39'h2_0000, -8, 5);
    wait_slot_valid(40);
    repeat (12) @(negedge clk);
    resume = 1'b0;
    wait_prefetch(20);
    repeat (12) @(negedge clk);
    close_test("back_pressure", e0);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/dispatch_select.sv ====
/* picks one source per cycle and forms the dispatch packet
   purely combinational apart from the checks */
`timescale 1ns/1ps
`default_nettype none

module dispatch_select
  import sched_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire issue_pkt_s   issue_pkt_i,
  input  wire late_wb_pkt_s late_wb_pkt_i,
  input  wire pref_req_s    pref_req_i,
  input  wire               hazard_i,
  input  wire               resume_i,
  input  wire               irq_pending_i,
  output dispatch_pkt_s     dispatch_pkt_o,
  output logic              late_wb_yumi_o,
  output logic              pref_yumi_o,
  output logic              fe_read_o
);

  logic issue_queued;
  logic wb_v;
  logic resume_v;
  logic pref_v;
  logic irq_v;

  // priority wb > resume > prefetch > irq > fetch queue
  assign issue_queued = issue_pkt_i.v & ~hazard_i;
  assign wb_v         = late_wb_pkt_i.v & (late_wb_pkt_i.force_v | ~issue_queued);
  assign resume_v     = ~late_wb_pkt_i.v & ~hazard_i & resume_i;
  assign pref_v       = pref_req_i.v & ~wb_v & ~resume_v;
  assign irq_v        = ~late_wb_pkt_i.v & ~hazard_i & ~resume_i & ~pref_req_i.v & irq_pending_i;
  assign fe_read_o    = issue_queued & ~(wb_v | resume_v | pref_v | irq_v);

  assign late_wb_yumi_o = wb_v;
  assign pref_yumi_o    = pref_v;

  always_comb
  begin
    dispatch_pkt_o     = '0;
    dispatch_pkt_o.v   = wb_v | resume_v | pref_v | irq_v | fe_read_o;
    dispatch_pkt_o.pc  = issue_pkt_i.pc;
    dispatch_pkt_o.src = e_src_none;
    if (wb_v)
    begin
      dispatch_pkt_o.src     = e_src_wb;
      dispatch_pkt_o.rd_addr = late_wb_pkt_i.rd_addr;
      dispatch_pkt_o.rs2     = late_wb_pkt_i.data;
    end
    else if (resume_v)
    begin
      dispatch_pkt_o.src        = e_src_resume;
      dispatch_pkt_o.exc.resume = 1'b1;
    end
    else if (pref_v)
    begin
      dispatch_pkt_o.src = e_src_pref;
      dispatch_pkt_o.rs1 = dword_t'(pref_req_i.addr);
    end
    else if (irq_v)
    begin
      dispatch_pkt_o.src     = e_src_irq;
      dispatch_pkt_o.exc.irq = 1'b1;
    end
    else if (fe_read_o)
    begin
      dispatch_pkt_o.instr = issue_pkt_i.instr;
      // no operand read here so the immediate rides in rs2
      dispatch_pkt_o.rs2   = issue_pkt_i.imm;
      if (issue_pkt_i.instr_v)
      begin
        dispatch_pkt_o.src = e_src_fe_instr;
      end
      else
      begin
        dispatch_pkt_o.src      = e_src_fe_exc;
        dispatch_pkt_o.rs1      = dword_t'(issue_pkt_i.pc);
        dispatch_pkt_o.exc.code = issue_pkt_i.exc_code;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({wb_v, resume_v, pref_v, irq_v, fe_read_o}));

  assert property (@(posedge clk_i) disable iff (rst_i)
    fe_read_o |-> issue_pkt_i.v && !hazard_i);

endmodule

`default_nettype wire

// ==== verilog/prefetch_arbiter.sv ====
/* drains pending tracker requests into a single prefetch slot
   the slot holds its request until the selector pulses yumi */
`timescale 1ns/1ps
`default_nettype none

module prefetch_arbiter
  import sched_pkg::*;
(
  input  wire                                  clk_i,
  input  wire                                  rst_i,
  input  wire entry_vec_t                      pend_i,
  input  wire vaddr_t [NUM_STRIDE_ENTRIES-1:0] pend_addr_i,
  input  wire                                  pref_yumi_i,
  output entry_vec_t                           grant_o,
  output pref_req_s                            pref_req_o
);

  logic       slot_v;
  vaddr_t     slot_addr;
  entry_idx_t sel_idx;

  // lowest index wins
  always_comb
  begin
    sel_idx = '0;
    for (int i = NUM_STRIDE_ENTRIES-1; i >= 0; i--)
    begin
      if (pend_i[i])
      begin
        sel_idx = entry_idx_t'(i);
      end
    end
  end

  assign grant_o = (!slot_v && pend_i != '0) ? entry_vec_t'(1) << sel_idx : '0;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      slot_v <= 1'b0;
    end
    else if (pref_yumi_i)
    begin
      slot_v <= 1'b0;
    end
    else if (grant_o != '0)
    begin
      slot_v <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (grant_o != '0)
    begin
      slot_addr <= pend_addr_i[sel_idx];
    end
  end

  assign pref_req_o = '{v: slot_v, addr: slot_addr};

  assert property (@(posedge clk_i) disable iff (rst_i)
    pref_req_o.v && !pref_yumi_i |=> pref_req_o.v && $stable(pref_req_o.addr));

endmodule

`default_nettype wire

// ==== verilog/sched_pkg.sv ====
/* widths, typedefs and packet formats shared by the scheduler core
   modules pull these in with a wildcard import in their header */
`default_nettype none

package sched_pkg;

  localparam int NUM_STRIDE_ENTRIES = 4;
  localparam int CONF_THRESHOLD     = 2;
  localparam int VADDR_WIDTH        = 39;
  localparam int DWORD_WIDTH        = 64;
  localparam int STRIDE_WIDTH       = 8;

  typedef logic [VADDR_WIDTH-1:0]                 vaddr_t;
  typedef logic [DWORD_WIDTH-1:0]                 dword_t;
  typedef logic [31:0]                            instr_t;
  typedef logic [4:0]                             reg_addr_t;
  typedef logic [STRIDE_WIDTH-1:0]                stride_t;
  typedef logic [$clog2(CONF_THRESHOLD+1)-1:0]    conf_t;
  typedef logic [$clog2(NUM_STRIDE_ENTRIES)-1:0]  entry_idx_t;
  typedef logic [NUM_STRIDE_ENTRIES-1:0]          entry_vec_t;
  typedef logic [3:0]                             exc_code_t;

  typedef enum logic [1:0] {e_idle, e_train, e_steady} entry_state_e;

  typedef enum logic [2:0] {
    e_src_none,
    e_src_wb,
    e_src_resume,
    e_src_pref,
    e_src_irq,
    e_src_fe_instr,
    e_src_fe_exc
  } dispatch_src_e;

  typedef struct packed {
    logic   v;
    logic   is_load;
    vaddr_t pc;
    vaddr_t vaddr;
  } commit_pkt_s;

  // head entry of the fetch queue
  typedef struct packed {
    logic      v;
    logic      instr_v;
    vaddr_t    pc;
    instr_t    instr;
    dword_t    imm;
    exc_code_t exc_code;
  } issue_pkt_s;

  typedef struct packed {
    logic      v;
    logic      force_v;
    reg_addr_t rd_addr;
    dword_t    data;
  } late_wb_pkt_s;

  typedef struct packed {
    logic   v;
    vaddr_t addr;
  } pref_req_s;

  typedef struct packed {
    logic          v;
    dispatch_src_e src;
    vaddr_t        pc;
    instr_t        instr;
    reg_addr_t     rd_addr;
    dword_t        rs1;
    dword_t        rs2;
    struct packed {
      logic      resume;
      logic      irq;
      exc_code_t code;
    } exc;
  } dispatch_pkt_s;

endpackage

`default_nettype wire

// ==== verilog/stride_alloc.sv ====
/* registers committed loads and steers each one to its stride tracker
   a miss replaces the tracker under the round-robin victim pointer */
`timescale 1ns/1ps
`default_nettype none

module stride_alloc
  import sched_pkg::*;
(
  input  wire                                  clk_i,
  input  wire                                  rst_i,
  input  wire commit_pkt_s                     commit_pkt_i,
  input  wire vaddr_t [NUM_STRIDE_ENTRIES-1:0] tag_pc_i,
  input  wire entry_vec_t                      tag_v_i,
  output entry_vec_t                           update_o,
  output entry_vec_t                           alloc_o,
  output vaddr_t                               upd_vaddr_o,
  output vaddr_t                               upd_pc_o
);

  logic       upd_v;
  entry_vec_t hit;
  entry_idx_t victim_ptr;
  logic       commit_load;

  assign commit_load = commit_pkt_i.v & commit_pkt_i.is_load;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      upd_v      <= 1'b0;
      victim_ptr <= '0;
    end
    else
    begin
      upd_v <= commit_load;
      if (alloc_o != '0)
      begin
        victim_ptr <= (victim_ptr == entry_idx_t'(NUM_STRIDE_ENTRIES-1)) ? '0
                                                                       : victim_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (commit_load)
    begin
      upd_pc_o    <= commit_pkt_i.pc;
      upd_vaddr_o <= commit_pkt_i.vaddr;
    end
  end

  always_comb
  begin
    for (int i = 0; i < NUM_STRIDE_ENTRIES; i++)
    begin
      hit[i] = tag_v_i[i] && (tag_pc_i[i] == upd_pc_o);
    end
  end

  assign update_o = upd_v ? hit : '0;
  assign alloc_o  = (upd_v && hit == '0) ? entry_vec_t'(1) << victim_ptr : '0;

  // tags stay unique across trackers so a load never hits twice
  assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(update_o) && $onehot0(alloc_o) && !((update_o != '0) && (alloc_o != '0)));

endmodule

`default_nettype wire

// ==== verilog/stride_entry.sv ====
/* one stride tracker with its training FSM and a pending prefetch
   instantiated once per tracker slot by the top level */
`timescale 1ns/1ps
`default_nettype none

module stride_entry
  import sched_pkg::*;
(
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         update_i,
  input  wire         alloc_i,
  input  wire vaddr_t upd_pc_i,
  input  wire vaddr_t upd_vaddr_i,
  input  wire         grant_i,
  output vaddr_t      tag_pc_o,
  output logic        tag_v_o,
  output logic        pend_o,
  output vaddr_t      pend_addr_o
);

  entry_state_e state;
  vaddr_t       last_addr;
  vaddr_t       addr_diff;
  stride_t      stride;
  stride_t      new_stride;
  conf_t        conf;
  logic         diff_fits;
  logic         stride_match;
  logic         pend_set;

  assign addr_diff = upd_vaddr_i - last_addr;
  // upper bits must be a pure sign extension
  assign diff_fits = (addr_diff[VADDR_WIDTH-1:STRIDE_WIDTH-1] == '0)
                  || (addr_diff[VADDR_WIDTH-1:STRIDE_WIDTH-1] == '1);
  assign new_stride   = diff_fits ? addr_diff[STRIDE_WIDTH-1:0] : '0;
  assign stride_match = (new_stride != '0) && (new_stride == stride);
  assign pend_set     = update_i && stride_match && (state == e_steady);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state   <= e_idle;
      tag_v_o <= 1'b0;
      conf    <= '0;
      pend_o  <= 1'b0;
    end
    else if (alloc_i)
    begin
      state   <= e_train;
      tag_v_o <= 1'b1;
      conf    <= '0;
      pend_o  <= 1'b0;
    end
    else
    begin
      pend_o <= pend_set | (pend_o & ~grant_i);
      if (update_i && !stride_match)
      begin
        conf  <= '0;
        state <= e_train;
      end
      else if (update_i && state != e_steady)
      begin
        conf <= conf + 1'b1;
        if (conf + 1'b1 >= CONF_THRESHOLD)
        begin
          state <= e_steady;
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (alloc_i)
    begin
      tag_pc_o  <= upd_pc_i;
      last_addr <= upd_vaddr_i;
      stride    <= '0;
    end
    else if (update_i)
    begin
      last_addr <= upd_vaddr_i;
      stride    <= new_stride;
    end
    if (pend_set)
    begin
      pend_addr_o <= upd_vaddr_i + {{(VADDR_WIDTH-STRIDE_WIDTH){stride[STRIDE_WIDTH-1]}}, stride};
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i) conf <= CONF_THRESHOLD);

endmodule

`default_nettype wire

// ==== verilog/stride_sched_top.sv ====
/* scheduler core top with the allocator and stride trackers
   feeding the prefetch arbiter and the dispatch selector */
`timescale 1ns/1ps
`default_nettype none

module stride_sched_top
  import sched_pkg::*;
(
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire commit_pkt_s  commit_pkt_i,
  input  wire issue_pkt_s   issue_pkt_i,
  input  wire late_wb_pkt_s late_wb_pkt_i,
  input  wire               hazard_i,
  input  wire               resume_i,
  input  wire               irq_pending_i,
  output dispatch_pkt_s     dispatch_pkt_o,
  output logic              late_wb_yumi_o,
  output logic              fe_read_o
);

  entry_vec_t                      update;
  entry_vec_t                      alloc;
  entry_vec_t                      tag_v;
  entry_vec_t                      pend;
  entry_vec_t                      grant;
  vaddr_t                          upd_pc;
  vaddr_t                          upd_vaddr;
  vaddr_t [NUM_STRIDE_ENTRIES-1:0] tag_pc;
  vaddr_t [NUM_STRIDE_ENTRIES-1:0] pend_addr;
  pref_req_s                       pref_req;
  logic                            pref_yumi;

  stride_alloc u_alloc (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .commit_pkt_i (commit_pkt_i),
    .tag_pc_i     (tag_pc),
    .tag_v_i      (tag_v),
    .update_o     (update),
    .alloc_o      (alloc),
    .upd_vaddr_o  (upd_vaddr),
    .upd_pc_o     (upd_pc)
  );

  for (genvar i = 0; i < NUM_STRIDE_ENTRIES; i++)
  begin : g_entry
    stride_entry u_entry (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .update_i    (update[i]),
      .alloc_i     (alloc[i]),
      .upd_pc_i    (upd_pc),
      .upd_vaddr_i (upd_vaddr),
      .grant_i     (grant[i]),
      .tag_pc_o    (tag_pc[i]),
      .tag_v_o     (tag_v[i]),
      .pend_o      (pend[i]),
      .pend_addr_o (pend_addr[i])
    );
  end

  prefetch_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .pend_i      (pend),
    .pend_addr_i (pend_addr),
    .pref_yumi_i (pref_yumi),
    .grant_o     (grant),
    .pref_req_o  (pref_req)
  );

  dispatch_select u_select (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .issue_pkt_i    (issue_pkt_i),
    .late_wb_pkt_i  (late_wb_pkt_i),
    .pref_req_i     (pref_req),
    .hazard_i       (hazard_i),
    .resume_i       (resume_i),
    .irq_pending_i  (irq_pending_i),
    .dispatch_pkt_o (dispatch_pkt_o),
    .late_wb_yumi_o (late_wb_yumi_o),
    .pref_yumi_o    (pref_yumi),
    .fe_read_o      (fe_read_o)
  );

endmodule

`default_nettype wire
